// File: vlog.f
common/cache_pkg.sv
common/axi_pkg.sv
cache/cache_bank.sv
rtl/cache_to_axi.sv
rtl/axi_mem.sv
rtl/cache_subsystem.sv
tests/cache_subsystem_properties.sv
tests/cache_subsystem_tb.sv

// File: tests/cache_subsystem_tb.sv
// cache subsystem testbench

module cache_subsystem_tb;

  localparam int num_banks_c = 2;
  localparam int sets_c = 8;
  localparam int block_words_c = 4;
  localparam int addr_width_c = 8;

  localparam int clk_period_c = 20;
  localparam int drive_delay_c = 2;
  localparam int directed_reqs_c = 14;
  localparam int random_reqs_c = 60;
  localparam int reqs_per_bank_c = directed_reqs_c + random_reqs_c;

  // a miss may wait for every other bank to evict and fill first
  localparam int miss_bound_c = num_banks_c * 2 * (block_words_c + 8) + 16;
  localparam longint timeout_c =
    longint'(num_banks_c * reqs_per_bank_c) * miss_bound_c * clk_period_c
    + 10 * clk_period_c;

  logic clk_i;
  logic reset_i;
  logic [num_banks_c-1:0] req_v_i;
  logic [num_banks_c-1:0] req_ready_o;
  cache_pkg::op_e [num_banks_c-1:0] req_op_i;
  logic [num_banks_c-1:0][addr_width_c-1:0] req_addr_i;
  cache_pkg::word_t [num_banks_c-1:0] req_data_i;
  logic [num_banks_c-1:0] resp_v_o;
  logic [num_banks_c-1:0] resp_ready_i;
  cache_pkg::word_t [num_banks_c-1:0] resp_data_o;

  integer seed;
  logic start;
  logic [num_banks_c-1:0] done;
  logic [num_banks_c-1:0] bp_on;  // random response back-pressure per bank

  cache_pkg::word_t shadow [num_banks_c][2**addr_width_c] = '{default: '0};

  // the one outstanding request of each bank
  logic [num_banks_c-1:0] exp_load;
  cache_pkg::word_t exp_word [num_banks_c];
  logic [addr_width_c-1:0] exp_addr [num_banks_c];
  int issued [num_banks_c];
  int resp_count [num_banks_c];

  wire [31:0] bank_prop_errors [num_banks_c];

  cache_subsystem #(
    .num_banks_p(num_banks_c)
    ,.sets_p(sets_c)
    ,.block_words_p(block_words_c)
    ,.addr_width_p(addr_width_c)
  ) uut (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.req_v_i(req_v_i)
    ,.req_ready_o(req_ready_o)
    ,.req_op_i(req_op_i)
    ,.req_addr_i(req_addr_i)
    ,.req_data_i(req_data_i)
    ,.resp_v_o(resp_v_o)
    ,.resp_ready_i(resp_ready_i)
    ,.resp_data_o(resp_data_o)
  );

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input int b, input logic [addr_width_c-1:0] addr,
      input cache_pkg::word_t got, input cache_pkg::word_t exp);
    if (got !== exp) begin
      $display("MISMATCH at time %0t: bank %0d load of %0h returned %h, expected %h",
               $time, b, addr, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int b, input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH at time %0t: bank %0d gave %0d responses, expected %0d",
               $time, b, got, exp);
      abort_run();
    end
  endtask

  // shadow memory per bank, never-written words read as zero
  function automatic cache_pkg::word_t model_access(input int b, input cache_pkg::op_e op,
      input logic [addr_width_c-1:0] addr, input cache_pkg::word_t data);
    if (op == cache_pkg::op_store) begin
      shadow[b][addr] = data;
      return '0;
    end
    return shadow[b][addr];
  endfunction

  task automatic access(input int b, input cache_pkg::op_e op,
      input logic [addr_width_c-1:0] addr, input cache_pkg::word_t data);
    req_v_i[b] = 1'b1;
    req_op_i[b] = op;
    req_addr_i[b] = addr;
    req_data_i[b] = data;
    @(posedge clk_i);
    while (!req_ready_o[b]) @(posedge clk_i);
    #drive_delay_c;
    req_v_i[b] = 1'b0;
    exp_word[b] = model_access(b, op, addr, data);
    exp_addr[b] = addr;
    exp_load[b] = (op == cache_pkg::op_load);
    issued[b]++;
    while (resp_count[b] != issued[b]) begin
      @(posedge clk_i);
      #drive_delay_c;
    end
  endtask

  task automatic run_directed(input int b);
    cache_pkg::word_t tagv;
    tagv = 32'h5a00_0000 | (b << 16);
    // cold loads come back as zero through a fill
    access(b, cache_pkg::op_load, 8'd3, '0);
    access(b, cache_pkg::op_load, 8'd17, '0);
    access(b, cache_pkg::op_load, 8'd200, '0);
    access(b, cache_pkg::op_store, 8'd5, tagv | 32'h05);
    access(b, cache_pkg::op_load, 8'd5, '0);
    access(b, cache_pkg::op_store, 8'd6, tagv | 32'h06);  // hits the line of word 5
    access(b, cache_pkg::op_load, 8'd6, '0);
    // 9 and 41 share line 2 with different tags
    access(b, cache_pkg::op_store, 8'd9, tagv | 32'h09);
    access(b, cache_pkg::op_load, 8'd41, '0);
    access(b, cache_pkg::op_load, 8'd9, '0);
    access(b, cache_pkg::op_load, 8'd41, '0);
    // every bank writes word 100 back to its own memory slice and reads it again
    access(b, cache_pkg::op_store, 8'd100, tagv | 32'h64);
    access(b, cache_pkg::op_load, 8'd132, '0);
    access(b, cache_pkg::op_load, 8'd100, '0);
  endtask

  task automatic run_random(input int b);
    cache_pkg::op_e op;
    logic [addr_width_c-1:0] addr;
    cache_pkg::word_t data;
    for (int n = 0; n < random_reqs_c; n++) begin
      op = cache_pkg::op_e'($random(seed) & 1);
      addr = addr_width_c'($random(seed) & 63);  // twice the cache size, hits and misses
      data = $random(seed);
      access(b, op, addr, data);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_c / 2) clk_i = ~clk_i;
  end

  for (genvar g = 0; g < num_banks_c; g++) begin : g_drv
    assign bank_prop_errors[g] = uut.g_bank[g].bank.bank_props.error_count;

    initial begin
      wait (start);
      run_directed(g);
      bp_on[g] = 1'b1;
      run_random(g);
      done[g] = 1'b1;
    end

    initial begin
      forever begin
        @(posedge clk_i);
        #drive_delay_c;
        if (bp_on[g]) resp_ready_i[g] = (($random(seed) & 3) != 0);
        else resp_ready_i[g] = 1'b1;
      end
    end
  end

  // compare process, one response handshake per bank and edge at most
  initial begin
    forever begin
      @(posedge clk_i);
      for (int b = 0; b < num_banks_c; b++) begin
        if (reset_i && resp_v_o[b] && resp_ready_i[b]) begin
          resp_count[b]++;
          // a response with no request outstanding pushes the count past the requests
          check_count(b, resp_count[b], issued[b]);
          if (exp_load[b]) check_word(b, exp_addr[b], resp_data_o[b], exp_word[b]);
        end
      end
    end
  end

  initial begin
    #(timeout_c);
    $display("timeout at time %0t: responses stalled before all requests completed", $time);
    abort_run();
  end

  initial begin
    int prop_errors;
    seed = 15928;
    start = 1'b0;
    done = '0;
    bp_on = '0;
    exp_load = '0;
    reset_i = 1'b0;
    req_v_i = '0;
    req_addr_i = '0;
    req_data_i = '0;
    resp_ready_i = '1;
    for (int b = 0; b < num_banks_c; b++) begin
      req_op_i[b] = cache_pkg::op_load;
      issued[b] = 0;
      resp_count[b] = 0;
    end
    repeat (4) @(posedge clk_i);
    #drive_delay_c;
    reset_i = 1'b1;
    start = 1'b1;
    wait (&done);
    @(posedge clk_i);
    #drive_delay_c;
    prop_errors = uut.bridge.bridge_props.error_count;
    for (int b = 0; b < num_banks_c; b++) prop_errors += bank_prop_errors[b];
    if (prop_errors == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("%0d assertion failures in the bound properties", prop_errors);
      abort_run();
    end
  end

endmodule

// File: tests/cache_subsystem_properties.sv
// bank and AXI handshake properties

module cache_subsystem_properties #(
  parameter bit axi_side_p = 1'b0
) (
  input logic clk_i
  ,input logic reset_i
  ,input logic resp_v_i
  ,input logic axi_awvalid_i
  ,input logic axi_awready_i
  ,input axi_pkg::len_t axi_awlen_i
  ,input logic axi_wvalid_i
  ,input logic axi_wready_i
  ,input logic axi_wlast_i
  ,input logic axi_arvalid_i
  ,input logic axi_arready_i
);

  int error_count = 0;
  axi_pkg::len_t beat_r;  // W beats taken in the current burst

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      beat_r <= '0;
    end else if (axi_wvalid_i && axi_wready_i) begin
      beat_r <= axi_wlast_i ? '0 : beat_r + 1'b1;
    end
  end

  if (axi_side_p) begin : g_axi
    assert property (@(posedge clk_i) disable iff (!reset_i)
      axi_awvalid_i && !axi_awready_i |=> axi_awvalid_i)
      else begin
        $error("awvalid dropped before awready");
        error_count++;
      end
    assert property (@(posedge clk_i) disable iff (!reset_i)
      axi_arvalid_i && !axi_arready_i |=> axi_arvalid_i)
      else begin
        $error("arvalid dropped before arready");
        error_count++;
      end
    // last must mark exactly the final beat of the burst
    assert property (@(posedge clk_i) disable iff (!reset_i)
      axi_wvalid_i |-> (axi_wlast_i == (beat_r == axi_awlen_i)))
      else begin
        $error("wlast does not match the final write beat");
        error_count++;
      end
  end else begin : g_bank
    assert property (@(posedge clk_i) $rose(reset_i) |-> !resp_v_i)
      else begin
        $error("resp_v_o high in the first cycle after reset");
        error_count++;
      end
  end

endmodule

bind cache_bank cache_subsystem_properties #(.axi_side_p(1'b0)) bank_props (
  .clk_i(clk_i)
  ,.reset_i(reset_i)
  ,.resp_v_i(resp_v_o)
  ,.axi_awvalid_i(1'b0)
  ,.axi_awready_i(1'b0)
  ,.axi_awlen_i(8'd0)
  ,.axi_wvalid_i(1'b0)
  ,.axi_wready_i(1'b0)
  ,.axi_wlast_i(1'b0)
  ,.axi_arvalid_i(1'b0)
  ,.axi_arready_i(1'b0)
);

bind cache_to_axi cache_subsystem_properties #(.axi_side_p(1'b1)) bridge_props (
  .clk_i(clk_i)
  ,.reset_i(reset_i)
  ,.resp_v_i(1'b0)
  ,.axi_awvalid_i(axi_awvalid_o)
  ,.axi_awready_i(axi_awready_i)
  ,.axi_awlen_i(axi_awlen_o)
  ,.axi_wvalid_i(axi_wvalid_o)
  ,.axi_wready_i(axi_wready_i)
  ,.axi_wlast_i(axi_wlast_o)
  ,.axi_arvalid_i(axi_arvalid_o)
  ,.axi_arready_i(axi_arready_i)
);

// File: rtl/cache_subsystem.sv
// banked data cache subsystem

module cache_subsystem #(
  parameter int num_banks_p = 2
  ,parameter int sets_p = 8
  ,parameter int block_words_p = 4
  ,parameter int addr_width_p = 8
  ,localparam int block_w_lp = addr_width_p - $clog2(block_words_p)
  ,localparam int bank_w_lp = (num_banks_p > 1) ? $clog2(num_banks_p) : 1
  ,localparam int axi_addr_w_lp =
    bank_w_lp + addr_width_p + $clog2(cache_pkg::data_width_c / 8)
) (
  input logic clk_i
  ,input logic reset_i

  ,input logic [num_banks_p-1:0] req_v_i
  ,output logic [num_banks_p-1:0] req_ready_o
  ,input cache_pkg::op_e [num_banks_p-1:0] req_op_i
  ,input logic [num_banks_p-1:0][addr_width_p-1:0] req_addr_i
  ,input cache_pkg::word_t [num_banks_p-1:0] req_data_i

  ,output logic [num_banks_p-1:0] resp_v_o
  ,input logic [num_banks_p-1:0] resp_ready_i
  ,output cache_pkg::word_t [num_banks_p-1:0] resp_data_o
);

  logic [num_banks_p-1:0] dma_v;
  logic [num_banks_p-1:0] dma_ready;
  cache_pkg::dma_dir_e [num_banks_p-1:0] dma_dir;
  logic [num_banks_p-1:0][block_w_lp-1:0] dma_addr;
  logic [num_banks_p-1:0] wdata_v;
  logic [num_banks_p-1:0] wdata_ready;
  cache_pkg::word_t [num_banks_p-1:0] wdata;
  logic [num_banks_p-1:0] rdata_v;
  logic [num_banks_p-1:0] rdata_ready;
  cache_pkg::word_t [num_banks_p-1:0] rdata;

  logic [axi_addr_w_lp-1:0] awaddr;
  axi_pkg::len_t awlen;
  logic awvalid;
  logic awready;
  cache_pkg::word_t wdata_axi;
  logic wlast;
  logic wvalid;
  logic wready;
  axi_pkg::resp_t bresp;
  logic bvalid;
  logic bready;
  logic [axi_addr_w_lp-1:0] araddr;
  axi_pkg::len_t arlen;
  logic arvalid;
  logic arready;
  cache_pkg::word_t rdata_axi;
  logic rlast;
  logic rvalid;
  logic rready;

  for (genvar i = 0; i < num_banks_p; i++) begin : g_bank
    cache_bank #(
      .sets_p(sets_p)
      ,.block_words_p(block_words_p)
      ,.addr_width_p(addr_width_p)
    ) bank (
      .clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.req_v_i(req_v_i[i])
      ,.req_ready_o(req_ready_o[i])
      ,.req_op_i(req_op_i[i])
      ,.req_addr_i(req_addr_i[i])
      ,.req_data_i(req_data_i[i])
      ,.resp_v_o(resp_v_o[i])
      ,.resp_ready_i(resp_ready_i[i])
      ,.resp_data_o(resp_data_o[i])
      ,.dma_v_o(dma_v[i])
      ,.dma_ready_i(dma_ready[i])
      ,.dma_dir_o(dma_dir[i])
      ,.dma_addr_o(dma_addr[i])
      ,.wdata_v_o(wdata_v[i])
      ,.wdata_ready_i(wdata_ready[i])
      ,.wdata_o(wdata[i])
      ,.rdata_v_i(rdata_v[i])
      ,.rdata_ready_o(rdata_ready[i])
      ,.rdata_i(rdata[i])
    );
  end

  cache_to_axi #(
    .num_banks_p(num_banks_p)
    ,.block_words_p(block_words_p)
    ,.addr_width_p(addr_width_p)
  ) bridge (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.dma_v_i(dma_v)
    ,.dma_ready_o(dma_ready)
    ,.dma_dir_i(dma_dir)
    ,.dma_addr_i(dma_addr)
    ,.wdata_v_i(wdata_v)
    ,.wdata_ready_o(wdata_ready)
    ,.wdata_i(wdata)
    ,.rdata_v_o(rdata_v)
    ,.rdata_ready_i(rdata_ready)
    ,.rdata_o(rdata)
    ,.axi_awaddr_o(awaddr)
    ,.axi_awlen_o(awlen)
    ,.axi_awvalid_o(awvalid)
    ,.axi_awready_i(awready)
    ,.axi_wdata_o(wdata_axi)
    ,.axi_wlast_o(wlast)
    ,.axi_wvalid_o(wvalid)
    ,.axi_wready_i(wready)
    ,.axi_bresp_i(bresp)
    ,.axi_bvalid_i(bvalid)
    ,.axi_bready_o(bready)
    ,.axi_araddr_o(araddr)
    ,.axi_arlen_o(arlen)
    ,.axi_arvalid_o(arvalid)
    ,.axi_arready_i(arready)
    ,.axi_rdata_i(rdata_axi)
    ,.axi_rlast_i(rlast)
    ,.axi_rvalid_i(rvalid)
    ,.axi_rready_o(rready)
  );

  axi_mem #(
    .num_banks_p(num_banks_p)
    ,.addr_width_p(addr_width_p)
  ) mem (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.axi_awaddr_i(awaddr)
    ,.axi_awlen_i(awlen)
    ,.axi_awvalid_i(awvalid)
    ,.axi_awready_o(awready)
    ,.axi_wdata_i(wdata_axi)
    ,.axi_wlast_i(wlast)
    ,.axi_wvalid_i(wvalid)
    ,.axi_wready_o(wready)
    ,.axi_bresp_o(bresp)
    ,.axi_bvalid_o(bvalid)
    ,.axi_bready_i(bready)
    ,.axi_araddr_i(araddr)
    ,.axi_arlen_i(arlen)
    ,.axi_arvalid_i(arvalid)
    ,.axi_arready_o(arready)
    ,.axi_rdata_o(rdata_axi)
    ,.axi_rlast_o(rlast)
    ,.axi_rvalid_o(rvalid)
    ,.axi_rready_i(rready)
  );

endmodule

// File: rtl/axi_mem.sv
// AXI memory model for incrementing bursts

module axi_mem #(
  parameter int num_banks_p = 2
  ,parameter int addr_width_p = 8
  ,localparam int bank_w_lp = (num_banks_p > 1) ? $clog2(num_banks_p) : 1
  ,localparam int byte_w_lp = $clog2(cache_pkg::data_width_c / 8)
  ,localparam int axi_addr_w_lp = bank_w_lp + addr_width_p + byte_w_lp
  ,localparam int mem_words_lp = num_banks_p * (2 ** addr_width_p)
) (
  input logic clk_i
  ,input logic reset_i

  ,input logic [axi_addr_w_lp-1:0] axi_awaddr_i
  ,input axi_pkg::len_t axi_awlen_i
  ,input logic axi_awvalid_i
  ,output logic axi_awready_o

  ,input cache_pkg::word_t axi_wdata_i
  ,input logic axi_wlast_i
  ,input logic axi_wvalid_i
  ,output logic axi_wready_o

  ,output axi_pkg::resp_t axi_bresp_o
  ,output logic axi_bvalid_o
  ,input logic axi_bready_i

  ,input logic [axi_addr_w_lp-1:0] axi_araddr_i
  ,input axi_pkg::len_t axi_arlen_i
  ,input logic axi_arvalid_i
  ,output logic axi_arready_o

  ,output cache_pkg::word_t axi_rdata_o
  ,output logic axi_rlast_o
  ,output logic axi_rvalid_o
  ,input logic axi_rready_i
);

  typedef enum logic [2:0] {
    st_idle
    ,st_aw
    ,st_w
    ,st_b
    ,st_ar
    ,st_r
  } state_e;

  state_e state_r;
  logic [bank_w_lp+addr_width_p-1:0] addr_r;  // word address of the current beat
  axi_pkg::len_t len_r;
  axi_pkg::len_t cnt_r;
  cache_pkg::word_t mem_r [mem_words_lp] = '{default: '0};

  assign axi_awready_o = (state_r == st_aw);
  assign axi_wready_o = (state_r == st_w);
  assign axi_bvalid_o = (state_r == st_b);
  assign axi_bresp_o = axi_pkg::resp_okay_c;
  assign axi_arready_o = (state_r == st_ar);
  assign axi_rvalid_o = (state_r == st_r);
  assign axi_rdata_o = mem_r[addr_r];
  assign axi_rlast_o = (cnt_r == len_r);

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_r <= st_idle;
    end else begin
      case (state_r)
        st_idle: begin
          if (axi_awvalid_i) state_r <= st_aw;  // writes first
          else if (axi_arvalid_i) state_r <= st_ar;
        end
        st_aw: state_r <= st_w;  // valid is held, so the handshake is certain
        st_w: begin
          if (axi_wvalid_i && (axi_wlast_i || (cnt_r == len_r))) state_r <= st_b;
        end
        st_b: begin
          if (axi_bready_i) state_r <= st_idle;
        end
        st_ar: state_r <= st_r;
        st_r: begin
          if (axi_rready_i && axi_rlast_o) state_r <= st_idle;
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_r)
      st_aw: begin
        addr_r <= axi_awaddr_i[axi_addr_w_lp-1:byte_w_lp];
        len_r <= axi_awlen_i;
        cnt_r <= '0;
      end
      st_ar: begin
        addr_r <= axi_araddr_i[axi_addr_w_lp-1:byte_w_lp];
        len_r <= axi_arlen_i;
        cnt_r <= '0;
      end
      st_w: begin
        if (axi_wvalid_i) begin
          mem_r[addr_r] <= axi_wdata_i;
          addr_r <= addr_r + 1'b1;
          cnt_r <= cnt_r + 1'b1;
        end
      end
      st_r: begin
        if (axi_rready_i) begin
          addr_r <= addr_r + 1'b1;
          cnt_r <= cnt_r + 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/cache_to_axi.sv
// round-robin block DMA to AXI bridge

module cache_to_axi #(
  parameter int num_banks_p = 2
  ,parameter int block_words_p = 4
  ,parameter int addr_width_p = 8
  ,localparam int bank_w_lp = (num_banks_p > 1) ? $clog2(num_banks_p) : 1
  ,localparam int offset_w_lp = $clog2(block_words_p)
  ,localparam int block_w_lp = addr_width_p - offset_w_lp
  ,localparam int byte_w_lp = $clog2(cache_pkg::data_width_c / 8)
  ,localparam int axi_addr_w_lp = bank_w_lp + addr_width_p + byte_w_lp
) (
  input logic clk_i
  ,input logic reset_i

  ,input logic [num_banks_p-1:0] dma_v_i
  ,output logic [num_banks_p-1:0] dma_ready_o
  ,input cache_pkg::dma_dir_e [num_banks_p-1:0] dma_dir_i
  ,input logic [num_banks_p-1:0][block_w_lp-1:0] dma_addr_i
  ,input logic [num_banks_p-1:0] wdata_v_i
  ,output logic [num_banks_p-1:0] wdata_ready_o
  ,input cache_pkg::word_t [num_banks_p-1:0] wdata_i
  ,output logic [num_banks_p-1:0] rdata_v_o
  ,input logic [num_banks_p-1:0] rdata_ready_i
  ,output cache_pkg::word_t [num_banks_p-1:0] rdata_o

  ,output logic [axi_addr_w_lp-1:0] axi_awaddr_o
  ,output axi_pkg::len_t axi_awlen_o
  ,output logic axi_awvalid_o
  ,input logic axi_awready_i

  ,output cache_pkg::word_t axi_wdata_o
  ,output logic axi_wlast_o
  ,output logic axi_wvalid_o
  ,input logic axi_wready_i

  ,input axi_pkg::resp_t axi_bresp_i
  ,input logic axi_bvalid_i
  ,output logic axi_bready_o

  ,output logic [axi_addr_w_lp-1:0] axi_araddr_o
  ,output axi_pkg::len_t axi_arlen_o
  ,output logic axi_arvalid_o
  ,input logic axi_arready_i

  ,input cache_pkg::word_t axi_rdata_i
  ,input logic axi_rlast_i
  ,input logic axi_rvalid_i
  ,output logic axi_rready_o
);

  typedef enum logic [2:0] {
    st_idle
    ,st_aw
    ,st_w
    ,st_b
    ,st_ar
    ,st_r
  } state_e;

  state_e state_r;
  logic [bank_w_lp-1:0] rr_ptr_r;
  logic [bank_w_lp-1:0] grant_r;
  logic [bank_w_lp-1:0] next_ptr;
  logic [axi_addr_w_lp-1:0] addr_r;
  axi_pkg::len_t beat_r;

  logic found;
  logic [bank_w_lp-1:0] pick;

  // first requesting bank at or after the round-robin pointer
  always_comb begin
    int idx;
    found = 1'b0;
    pick = rr_ptr_r;
    for (int k = 0; k < num_banks_p; k++) begin
      idx = (int'(rr_ptr_r) + k) % num_banks_p;
      if (!found && dma_v_i[idx]) begin
        found = 1'b1;
        pick = bank_w_lp'(idx);
      end
    end
  end

  assign next_ptr = (grant_r == bank_w_lp'(num_banks_p - 1)) ? '0 : grant_r + 1'b1;

  always_comb begin
    for (int i = 0; i < num_banks_p; i++) begin
      dma_ready_o[i] = (state_r == st_idle) && found && (pick == bank_w_lp'(i));
      wdata_ready_o[i] = (state_r == st_w) && (grant_r == bank_w_lp'(i)) && axi_wready_i;
      rdata_v_o[i] = (state_r == st_r) && (grant_r == bank_w_lp'(i)) && axi_rvalid_i;
      rdata_o[i] = axi_rdata_i;  // only the granted bank sees valid
    end
  end

  assign axi_awaddr_o = addr_r;
  assign axi_awlen_o = axi_pkg::len_t'(block_words_p - 1);
  assign axi_awvalid_o = (state_r == st_aw);

  assign axi_wdata_o = wdata_i[grant_r];
  assign axi_wvalid_o = (state_r == st_w) && wdata_v_i[grant_r];
  assign axi_wlast_o = (beat_r == axi_pkg::len_t'(block_words_p - 1));

  assign axi_bready_o = (state_r == st_b);

  assign axi_araddr_o = addr_r;
  assign axi_arlen_o = axi_pkg::len_t'(block_words_p - 1);
  assign axi_arvalid_o = (state_r == st_ar);

  assign axi_rready_o = (state_r == st_r) && rdata_ready_i[grant_r];

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_r <= st_idle;
      rr_ptr_r <= '0;
      beat_r <= '0;
    end else begin
      case (state_r)
        st_idle: begin
          if (found) begin
            state_r <= (dma_dir_i[pick] == cache_pkg::dma_evict) ? st_aw : st_ar;
          end
        end
        st_aw: begin
          if (axi_awready_i) begin
            state_r <= st_w;
            beat_r <= '0;
          end
        end
        st_w: begin
          if (axi_wvalid_o && axi_wready_i) begin
            beat_r <= beat_r + 1'b1;
            if (axi_wlast_o) state_r <= st_b;
          end
        end
        st_b: begin
          // grant ends with the write response
          if (axi_bvalid_i) begin
            state_r <= st_idle;
            rr_ptr_r <= next_ptr;
          end
        end
        st_ar: begin
          if (axi_arready_i) state_r <= st_r;
        end
        st_r: begin
          if (axi_rvalid_i && axi_rready_o && axi_rlast_i) begin
            state_r <= st_idle;
            rr_ptr_r <= next_ptr;
          end
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  // bank index goes in the top address bits
  always_ff @(posedge clk_i) begin
    if ((state_r == st_idle) && found) begin
      grant_r <= pick;
      addr_r <= {pick, dma_addr_i[pick], {(offset_w_lp + byte_w_lp){1'b0}}};
    end
  end

endmodule

// File: cache/cache_bank.sv
// direct-mapped write-back cache bank

module cache_bank #(
  parameter int sets_p = 8
  ,parameter int block_words_p = 4
  ,parameter int addr_width_p = 8
  ,localparam int offset_w_lp = $clog2(block_words_p)
  ,localparam int index_w_lp = $clog2(sets_p)
  ,localparam int tag_w_lp = addr_width_p - offset_w_lp - index_w_lp
  ,localparam int block_w_lp = addr_width_p - offset_w_lp
) (
  input logic clk_i
  ,input logic reset_i

  ,input logic req_v_i
  ,output logic req_ready_o
  ,input cache_pkg::op_e req_op_i
  ,input logic [addr_width_p-1:0] req_addr_i
  ,input cache_pkg::word_t req_data_i

  ,output logic resp_v_o
  ,input logic resp_ready_i
  ,output cache_pkg::word_t resp_data_o

  ,output logic dma_v_o
  ,input logic dma_ready_i
  ,output cache_pkg::dma_dir_e dma_dir_o
  ,output logic [block_w_lp-1:0] dma_addr_o

  ,output logic wdata_v_o
  ,input logic wdata_ready_i
  ,output cache_pkg::word_t wdata_o

  ,input logic rdata_v_i
  ,output logic rdata_ready_o
  ,input cache_pkg::word_t rdata_i
);

  typedef enum logic [2:0] {
    st_idle
    ,st_lookup
    ,st_evict_cmd
    ,st_evict_data
    ,st_fill_cmd
    ,st_fill_data
    ,st_respond
  } state_e;

  state_e state_r;
  logic init_r;
  logic [sets_p-1:0] valid_r;
  logic [sets_p-1:0] dirty_r;
  logic [sets_p-1:0][tag_w_lp-1:0] tag_r;
  cache_pkg::word_t data_r [sets_p*block_words_p];

  // the request being served
  cache_pkg::op_e op_r;
  logic [addr_width_p-1:0] addr_r;
  cache_pkg::word_t wr_data_r;

  logic [offset_w_lp-1:0] cnt_r;  // word within the line during evict and fill

  logic [index_w_lp-1:0] index;
  logic [offset_w_lp-1:0] offset;
  logic [tag_w_lp-1:0] tag;
  logic hit;
  logic cnt_last;

  assign index = addr_r[offset_w_lp +: index_w_lp];
  assign offset = addr_r[offset_w_lp-1:0];
  assign tag = addr_r[addr_width_p-1 -: tag_w_lp];
  assign hit = valid_r[index] && (tag_r[index] == tag);
  assign cnt_last = (cnt_r == offset_w_lp'(block_words_p - 1));

  // not ready in the first cycle out of reset
  assign req_ready_o = init_r && (state_r == st_idle);

  // a hit answers straight from lookup, one cycle after acceptance
  assign resp_v_o = (state_r == st_respond) || ((state_r == st_lookup) && hit);
  assign resp_data_o = data_r[{index, offset}];

  assign dma_v_o = (state_r == st_evict_cmd) || (state_r == st_fill_cmd);
  assign dma_dir_o = (state_r == st_evict_cmd) ? cache_pkg::dma_evict : cache_pkg::dma_fill;
  assign dma_addr_o = (state_r == st_evict_cmd) ? {tag_r[index], index}
                                                : addr_r[addr_width_p-1:offset_w_lp];

  assign wdata_v_o = (state_r == st_evict_data);
  assign wdata_o = data_r[{index, cnt_r}];
  assign rdata_ready_o = (state_r == st_fill_data);

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_r <= st_idle;
      init_r <= 1'b0;
      valid_r <= '0;
      dirty_r <= '0;
      tag_r <= '0;
      cnt_r <= '0;
    end else begin
      init_r <= 1'b1;
      case (state_r)
        st_idle: begin
          if (req_v_i && req_ready_o) state_r <= st_lookup;
        end
        st_lookup: begin
          if (hit) begin
            if (op_r == cache_pkg::op_store) dirty_r[index] <= 1'b1;
            state_r <= resp_ready_i ? st_idle : st_respond;
          end else if (valid_r[index] && dirty_r[index]) begin
            state_r <= st_evict_cmd;  // victim must go out before the fill
          end else begin
            state_r <= st_fill_cmd;
          end
        end
        st_evict_cmd: begin
          if (dma_ready_i) begin
            state_r <= st_evict_data;
            cnt_r <= '0;
          end
        end
        st_evict_data: begin
          if (wdata_ready_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (cnt_last) state_r <= st_fill_cmd;
          end
        end
        st_fill_cmd: begin
          if (dma_ready_i) begin
            state_r <= st_fill_data;
            cnt_r <= '0;
          end
        end
        st_fill_data: begin
          if (rdata_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (cnt_last) begin
              tag_r[index] <= tag;
              valid_r[index] <= 1'b1;
              dirty_r[index] <= 1'b0;
              state_r <= st_lookup;  // the pending access now hits
            end
          end
        end
        st_respond: begin
          if (resp_ready_i) state_r <= st_idle;
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i && req_ready_o) begin
      op_r <= req_op_i;
      addr_r <= req_addr_i;
      wr_data_r <= req_data_i;
    end
  end

  // line data, written by fill beats and by a store hit
  always_ff @(posedge clk_i) begin
    if ((state_r == st_fill_data) && rdata_v_i) begin
      data_r[{index, cnt_r}] <= rdata_i;
    end else if ((state_r == st_lookup) && hit && (op_r == cache_pkg::op_store)) begin
      data_r[{index, offset}] <= wr_data_r;
    end
  end

endmodule

// File: common/axi_pkg.sv
// AXI side types and constants

package axi_pkg;

  typedef logic [7:0] len_t;  // number of beats minus one

  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay_c = 2'b00;

endpackage

// File: common/cache_pkg.sv
// cache side types and constants

package cache_pkg;

  localparam int data_width_c = 32;

  typedef logic [data_width_c-1:0] word_t;

  typedef enum logic {
    op_load   = 1'b0
    ,op_store = 1'b1
  } op_e;

  // direction of one block transfer between a bank and memory
  typedef enum logic {
    dma_fill   = 1'b0  // memory to cache
    ,dma_evict = 1'b1  // cache to memory
  } dma_dir_e;

endpackage
